// File: source/pipe_defines.svh
// width and depth macros for the memory/writeback pipeline, include where a size is needed
`ifndef PIPE_DEFINES_SVH
`define PIPE_DEFINES_SVH

// data and address width
`define WORD_W 32

// register file address width
`define REG_W 5

// data ram depth in words
`define DMEM_WORDS 256

`endif

// File: source/cpu_types_pkg.sv
// basic processor types shared by every pipeline stage, imported by stages and other packages
`include "pipe_defines.svh"

package cpu_types_pkg;

    // one machine word
    typedef logic [`WORD_W-1:0] word_t;

    // register number
    typedef logic [`REG_W-1:0] regbits_t;

    // writeback source select
    typedef enum logic [1:0] {
        // alu result
        WSEL_ALU  = 2'd0,
        // link address for jal
        WSEL_NPC  = 2'd1,
        // word from data memory
        WSEL_LOAD = 2'd2,
        // extended immediate, lui style
        WSEL_IMM  = 2'd3
    } wsel_t;

endpackage

// File: source/pipe_types_pkg.sv
// pipeline latch, data request and wishbone bus types, imported by the memory side modules
package pipe_types_pkg;

    import cpu_types_pkg::*;

    // execute/memory latch
    typedef struct packed {
        word_t    PC;
        word_t    NPC;
        word_t    Instruction;
        word_t    port_a;
        word_t    port_b;
        word_t    port_o;
        word_t    Imm_Ext;
        word_t    BranchAddr;
        regbits_t Rw;
        logic     RegWEN;
        wsel_t    MemtoReg;
        logic     dREN;
        logic     dWEN;
        logic     halt;
        logic     BEQ;
        logic     BNE;
        logic     zero;
        // prediction made in fetch
        logic     branch_taken;
        logic     emergency_flush;
        logic [1:0] JumpSel;
    } execute_t;

    // memory/writeback latch
    typedef struct packed {
        regbits_t Rw;
        logic     RegWEN;
        wsel_t    MemtoReg;
        logic     halt;
        word_t    NPC;
        word_t    port_o;
        word_t    dmemload;
        word_t    Imm_Ext;
    } memory_t;

    // data request toward the bus master
    typedef struct packed {
        logic  ren;
        logic  wen;
        word_t addr;
        word_t store;
    } dmem_req_t;

    // branch resolution back to fetch
    typedef struct packed {
        logic       BranchTaken;
        logic       branch_mispredict;
        word_t      BranchAddr;
        word_t      JumpAddr;
        logic [1:0] JumpSel;
        word_t      port_a;
        word_t      PC;
    } branch_res_t;

    // wishbone classic, master to slave
    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        word_t adr;
        word_t dat;
    } wb_m2s_t;

    // wishbone classic, slave to master
    typedef struct packed {
        logic  ack;
        word_t dat;
    } wb_s2m_t;

    // register file write port
    typedef struct packed {
        logic     wen;
        regbits_t wsel;
        word_t    wdat;
    } regwrite_t;

    // bus master states
    typedef enum logic {
        BUS_IDLE = 1'b0,
        BUS_WAIT = 1'b1
    } bus_state_t;

endpackage

// File: source/memory_stage.sv
// memory stage: data request, branch resolution, forwarding data and the mem/wb latch
`timescale 1ns/1ps
`include "pipe_defines.svh"

module memory_stage (
    input  logic                       CLK,
    input  logic                       nRST,
    input  pipe_types_pkg::execute_t    execute_p,
    input  logic                       ihit,
    input  logic                       flush,
    input  logic                       freeze,
    input  logic                       dhit,
    input  cpu_types_pkg::word_t        dmemload,
    output pipe_types_pkg::dmem_req_t   dmem_req,
    output logic                       mem_busy,
    output pipe_types_pkg::memory_t     memory_p,
    output pipe_types_pkg::branch_res_t branch_res,
    output cpu_types_pkg::word_t        forwarding_unit_data
);

    import cpu_types_pkg::*;
    import pipe_types_pkg::*;

    memory_t next_memory;
    word_t   load_q;
    logic    access_done;
    logic    advance;
    logic    is_branch;

    // latch moves only once the data access has finished
    assign advance = ihit & ~mem_busy & ~freeze;

    // set on dhit, cleared when the instruction leaves
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            access_done <= 1'b0;
        end else if (advance) begin
            access_done <= 1'b0;
        end else if (dhit) begin
            access_done <= 1'b1;
        end
    end

    // load data held until the latch advances
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            load_q <= '0;
        end else if (dhit) begin
            load_q <= dmemload;
        end
    end

    // stores are dropped once halt reaches this stage
    always_comb begin
        dmem_req.ren   = execute_p.dREN & ~access_done;
        dmem_req.wen   = execute_p.dWEN & ~execute_p.halt & ~access_done;
        dmem_req.addr  = execute_p.port_o;
        dmem_req.store = execute_p.port_b;
    end

    assign mem_busy = dmem_req.ren | dmem_req.wen;

    always_comb begin
        next_memory.Rw       = execute_p.Rw;
        next_memory.RegWEN   = execute_p.RegWEN;
        next_memory.MemtoReg = execute_p.MemtoReg;
        next_memory.halt     = execute_p.halt;
        next_memory.NPC      = execute_p.NPC;
        next_memory.port_o   = execute_p.port_o;
        next_memory.dmemload = load_q;
        next_memory.Imm_Ext  = execute_p.Imm_Ext;
    end

    // flush wins over freeze and advance
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            memory_p <= '0;
        end else if (flush) begin
            memory_p <= '0;
        end else if (advance) begin
            memory_p <= next_memory;
        end
    end

    assign is_branch = execute_p.BEQ | execute_p.BNE;

    always_comb begin
        branch_res.BranchTaken = (execute_p.BEQ & execute_p.zero) |
                                 (execute_p.BNE & ~execute_p.zero);
        // wrong direction, or a taken guess whose target was bad
        branch_res.branch_mispredict = is_branch &
            ((execute_p.branch_taken != branch_res.BranchTaken) |
             (execute_p.branch_taken & execute_p.emergency_flush));
        branch_res.BranchAddr = execute_p.BranchAddr;
        branch_res.JumpAddr   = {execute_p.NPC[`WORD_W-1 -: 4],
                                 execute_p.Instruction[25:0], 2'b00};
        branch_res.JumpSel    = execute_p.JumpSel;
        branch_res.port_a     = execute_p.port_a;
        branch_res.PC         = execute_p.PC;
    end

    // load data is not ready yet, so nothing to forward
    always_comb begin
        case (execute_p.MemtoReg)
            WSEL_ALU: forwarding_unit_data = execute_p.port_o;
            WSEL_NPC: forwarding_unit_data = execute_p.NPC;
            WSEL_IMM: forwarding_unit_data = execute_p.Imm_Ext;
            default:  forwarding_unit_data = '0;
        endcase
    end

endmodule

// File: source/dmem_bus_master.sv
// wishbone classic master that runs one bus cycle per data request from the memory stage
`timescale 1ns/1ps
`include "pipe_defines.svh"

module dmem_bus_master (
    input  logic                     CLK,
    input  logic                     nRST,
    input  pipe_types_pkg::dmem_req_t dmem_req,
    output logic                     dhit,
    output cpu_types_pkg::word_t      dmemload,
    output pipe_types_pkg::wb_m2s_t   wb_m2s,
    input  pipe_types_pkg::wb_s2m_t   wb_s2m
);

    import pipe_types_pkg::*;

    bus_state_t state;
    wb_m2s_t    m2s_q;
    logic       req_valid;

    assign req_valid = dmem_req.ren | dmem_req.wen;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= BUS_IDLE;
            m2s_q <= '0;
        end else begin
            case (state)
                BUS_IDLE: begin
                    if (req_valid) begin
                        state     <= BUS_WAIT;
                        m2s_q.cyc <= 1'b1;
                        m2s_q.stb <= 1'b1;
                        m2s_q.we  <= dmem_req.wen;
                        // byte address to word address
                        m2s_q.adr <= {2'b00, dmem_req.addr[`WORD_W-1:2]};
                        m2s_q.dat <= dmem_req.store;
                    end
                end
                BUS_WAIT: begin
                    // adr, we and dat stay put until ack
                    if (wb_s2m.ack) begin
                        state     <= BUS_IDLE;
                        m2s_q.cyc <= 1'b0;
                        m2s_q.stb <= 1'b0;
                        m2s_q.we  <= 1'b0;
                    end
                end
                default: begin
                    state <= BUS_IDLE;
                end
            endcase
        end
    end

    assign wb_m2s = m2s_q;

    // hit in the ack cycle, data straight from the slave
    assign dhit     = (state == BUS_WAIT) & wb_s2m.ack;
    assign dmemload = wb_s2m.dat;

endmodule

// File: source/data_ram.sv
// wishbone classic slave ram backing the data memory, one registered ack per strobe
`timescale 1ns/1ps
`include "pipe_defines.svh"

module data_ram (
    input  logic                   CLK,
    input  logic                   nRST,
    input  pipe_types_pkg::wb_m2s_t wb_m2s,
    output pipe_types_pkg::wb_s2m_t wb_s2m
);

    localparam int ADDR_W = $clog2(`DMEM_WORDS);

    logic [`WORD_W-1:0] mem [`DMEM_WORDS];
    logic [ADDR_W-1:0]  idx;
    logic [`WORD_W-1:0] rdat_q;
    logic               ack_q;
    logic               access;

    // word index from the low address bits
    assign idx = wb_m2s.adr[ADDR_W-1:0];

    // master still holds stb in the cycle of our ack
    assign access = wb_m2s.cyc & wb_m2s.stb & ~ack_q;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    // write lands on the edge that raises ack
    always_ff @(posedge CLK) begin
        if (access && wb_m2s.we) begin
            mem[idx] <= wb_m2s.dat;
        end
        if (access) begin
            rdat_q <= mem[idx];
        end
    end

    assign wb_s2m.ack = ack_q;
    assign wb_s2m.dat = rdat_q;

endmodule

// File: source/writeback_stage.sv
// writeback stage turning the mem/wb latch into a register file write and the halt flag
`timescale 1ns/1ps

module writeback_stage (
    input  pipe_types_pkg::memory_t   memory_p,
    output pipe_types_pkg::regwrite_t regwrite,
    output logic                     halt
);

    import cpu_types_pkg::*;

    word_t wdat;

    // pick the value to write back
    always_comb begin
        case (memory_p.MemtoReg)
            WSEL_ALU:  wdat = memory_p.port_o;
            WSEL_NPC:  wdat = memory_p.NPC;
            WSEL_LOAD: wdat = memory_p.dmemload;
            WSEL_IMM:  wdat = memory_p.Imm_Ext;
            default:   wdat = memory_p.port_o;
        endcase
    end

    // register zero is hardwired, never written
    always_comb begin
        regwrite.wen  = memory_p.RegWEN & (memory_p.Rw != '0);
        regwrite.wsel = memory_p.Rw;
        regwrite.wdat = wdat;
    end

    assign halt = memory_p.halt;

endmodule

// File: source/mem_wb_top.sv
// top level joining memory stage, wishbone data path, data ram and writeback stage
`timescale 1ns/1ps

module mem_wb_top (
    input  logic                       CLK,
    input  logic                       nRST,
    input  pipe_types_pkg::execute_t    execute_p,
    input  logic                       ihit,
    input  logic                       flush,
    input  logic                       freeze,
    output pipe_types_pkg::branch_res_t branch_res,
    output cpu_types_pkg::word_t        forwarding_unit_data,
    output logic                       mem_busy,
    output pipe_types_pkg::regwrite_t   regwrite,
    output logic                       halt
);

    import cpu_types_pkg::*;
    import pipe_types_pkg::*;

    dmem_req_t dmem_req;
    logic      dhit;
    word_t     dmemload;
    wb_m2s_t   wb_m2s;
    wb_s2m_t   wb_s2m;
    memory_t   memory_p;

    memory_stage u_memory_stage (
        .CLK                  (CLK),
        .nRST                 (nRST),
        .execute_p            (execute_p),
        .ihit                 (ihit),
        .flush                (flush),
        .freeze               (freeze),
        .dhit                 (dhit),
        .dmemload             (dmemload),
        .dmem_req             (dmem_req),
        .mem_busy             (mem_busy),
        .memory_p             (memory_p),
        .branch_res           (branch_res),
        .forwarding_unit_data (forwarding_unit_data)
    );

    dmem_bus_master u_dmem_bus_master (
        .CLK      (CLK),
        .nRST     (nRST),
        .dmem_req (dmem_req),
        .dhit     (dhit),
        .dmemload (dmemload),
        .wb_m2s   (wb_m2s),
        .wb_s2m   (wb_s2m)
    );

    data_ram u_data_ram (
        .CLK    (CLK),
        .nRST   (nRST),
        .wb_m2s (wb_m2s),
        .wb_s2m (wb_s2m)
    );

    writeback_stage u_writeback_stage (
        .memory_p (memory_p),
        .regwrite (regwrite),
        .halt     (halt)
    );

endmodule

// File: test/mem_wb_assert.sv
// concurrent protocol and pipeline checks, attached to mem_wb_top by the bind at the bottom
`timescale 1ns/1ps

module mem_wb_assert (
    input logic                        CLK,
    input logic                        nRST,
    input pipe_types_pkg::execute_t    execute_p,
    input logic                        ihit,
    input logic                        flush,
    input logic                        freeze,
    input pipe_types_pkg::branch_res_t branch_res,
    input cpu_types_pkg::word_t        forwarding_unit_data,
    input logic                        mem_busy,
    input pipe_types_pkg::regwrite_t   regwrite,
    input logic                        halt,
    input logic                        dhit,
    input pipe_types_pkg::wb_m2s_t     wb_m2s,
    input pipe_types_pkg::wb_s2m_t     wb_s2m
);

    import cpu_types_pkg::*;
    import pipe_types_pkg::*;

    int    fail_count = 0;
    logic  taken;
    logic  mispredict;
    word_t jump_addr;
    word_t fwd_exp;
    logic  advancing;

    always_comb begin
        taken      = (execute_p.BEQ && execute_p.zero) || (execute_p.BNE && !execute_p.zero);
        mispredict = (execute_p.BEQ || execute_p.BNE) &&
                     ((execute_p.branch_taken != taken) ||
                      (execute_p.branch_taken && execute_p.emergency_flush));
        jump_addr  = {execute_p.NPC[31:28], execute_p.Instruction[25:0], 2'b00};
        advancing  = ihit && !mem_busy && !freeze;
        case (execute_p.MemtoReg)
            WSEL_ALU: fwd_exp = execute_p.port_o;
            WSEL_NPC: fwd_exp = execute_p.NPC;
            WSEL_IMM: fwd_exp = execute_p.Imm_Ext;
            default:  fwd_exp = '0;
        endcase
    end

    // branch outcome and targets
    branch_taken_chk: assert property (@(posedge CLK) disable iff (!nRST)
        branch_res.BranchTaken == taken)
        else begin
            fail_count++;
            $error("BranchTaken does not follow BEQ/BNE and zero");
        end

    mispredict_chk: assert property (@(posedge CLK) disable iff (!nRST)
        branch_res.branch_mispredict == mispredict)
        else begin
            fail_count++;
            $error("branch_mispredict is wrong");
        end

    jump_addr_chk: assert property (@(posedge CLK) disable iff (!nRST)
        branch_res.JumpAddr == jump_addr)
        else begin
            fail_count++;
            $error("JumpAddr is wrong");
        end

    // fields handed back to fetch unchanged
    branch_pass_chk: assert property (@(posedge CLK) disable iff (!nRST)
        branch_res.BranchAddr == execute_p.BranchAddr &&
        branch_res.JumpSel == execute_p.JumpSel &&
        branch_res.port_a == execute_p.port_a &&
        branch_res.PC == execute_p.PC)
        else begin
            fail_count++;
            $error("branch target, JumpSel, port_a or PC not passed through");
        end

    forward_chk: assert property (@(posedge CLK) disable iff (!nRST)
        forwarding_unit_data == fwd_exp)
        else begin
            fail_count++;
            $error("forwarding data does not follow MemtoReg");
        end

    // wishbone classic handshake
    stb_cyc_chk: assert property (@(posedge CLK) disable iff (!nRST)
        wb_m2s.stb |-> wb_m2s.cyc)
        else begin
            fail_count++;
            $error("stb raised without cyc");
        end

    stb_ack_chk: assert property (@(posedge CLK) disable iff (!nRST)
        $rose(wb_m2s.stb) |=> wb_s2m.ack)
        else begin
            fail_count++;
            $error("ack did not follow stb by one cycle");
        end

    ack_pulse_chk: assert property (@(posedge CLK) disable iff (!nRST)
        wb_s2m.ack |=> !wb_s2m.ack)
        else begin
            fail_count++;
            $error("ack lasted more than one cycle");
        end

    dhit_delay_chk: assert property (@(posedge CLK) disable iff (!nRST)
        $rose(mem_busy) |-> ##2 dhit)
        else begin
            fail_count++;
            $error("dhit did not arrive two cycles after the request");
        end

    busy_drop_chk: assert property (@(posedge CLK) disable iff (!nRST)
        dhit |=> !mem_busy)
        else begin
            fail_count++;
            $error("mem_busy still high after dhit");
        end

    // halted stores never reach the bus
    halt_store_chk: assert property (@(posedge CLK) disable iff (!nRST)
        execute_p.halt |=> !(wb_m2s.stb && wb_m2s.we))
        else begin
            fail_count++;
            $error("bus write started while halt is set");
        end

    halt_out_chk: assert property (@(posedge CLK) disable iff (!nRST)
        (advancing && !flush && execute_p.halt) |=> halt)
        else begin
            fail_count++;
            $error("halt output did not rise after the advance");
        end

    flush_chk: assert property (@(posedge CLK) disable iff (!nRST)
        flush |=> !regwrite.wen)
        else begin
            fail_count++;
            $error("register write still enabled after flush");
        end

    freeze_chk: assert property (@(posedge CLK) disable iff (!nRST)
        (freeze && !flush) |=> $stable(regwrite))
        else begin
            fail_count++;
            $error("regwrite changed during freeze");
        end

endmodule

bind mem_wb_top mem_wb_assert u_assert (
    .CLK                  (CLK),
    .nRST                 (nRST),
    .execute_p            (execute_p),
    .ihit                 (ihit),
    .flush                (flush),
    .freeze               (freeze),
    .branch_res           (branch_res),
    .forwarding_unit_data (forwarding_unit_data),
    .mem_busy             (mem_busy),
    .regwrite             (regwrite),
    .halt                 (halt),
    .dhit                 (dhit),
    .wb_m2s               (wb_m2s),
    .wb_s2m               (wb_s2m)
);

// File: test/mem_wb_tb.sv
// random instruction stream testbench for mem_wb_top with a store mirror scoreboard
`timescale 1ns/1ps

module mem_wb_tb;

    import cpu_types_pkg::*;
    import pipe_types_pkg::*;

    localparam int NUM_INSTR = 60;
    localparam int MAX_CYCLES = NUM_INSTR * 8 + 50;

    logic        CLK = 1'b0;
    logic        nRST;
    execute_t    execute_p;
    logic        ihit;
    logic        flush;
    logic        freeze;
    branch_res_t branch_res;
    word_t       forwarding_unit_data;
    logic        mem_busy;
    regwrite_t   regwrite;
    logic        halt;

    word_t mirror [8];
    logic  stored [8];
    int    errors = 0;
    int    cycles = 0;

    mem_wb_top UUT (
        .CLK                  (CLK),
        .nRST                 (nRST),
        .execute_p            (execute_p),
        .ihit                 (ihit),
        .flush                (flush),
        .freeze               (freeze),
        .branch_res           (branch_res),
        .forwarding_unit_data (forwarding_unit_data),
        .mem_busy             (mem_busy),
        .regwrite             (regwrite),
        .halt                 (halt)
    );

    always #2 CLK = ~CLK;

    // run limit
    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("run stopped after %0d cycles without finishing the sequence", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    // random instruction whose memory ops use one of eight word slots
    function automatic execute_t make_instr(input int n, output string name);
        execute_t e;
        int       kind;
        int       slot;
        kind = $urandom % 8;
        slot = $urandom % 8;
        e.PC              = $urandom;
        e.NPC             = $urandom;
        e.Instruction     = $urandom;
        e.port_a          = $urandom;
        e.port_b          = $urandom;
        e.port_o          = $urandom;
        e.Imm_Ext         = $urandom;
        e.BranchAddr      = $urandom;
        e.Rw              = 5'($urandom);
        e.RegWEN          = 1'($urandom);
        e.MemtoReg        = wsel_t'($urandom % 4);
        e.dREN            = 1'b0;
        e.dWEN            = 1'b0;
        e.halt            = 1'b0;
        e.BEQ             = 1'($urandom);
        e.BNE             = !e.BEQ && 1'($urandom);
        e.zero            = 1'($urandom);
        e.branch_taken    = 1'($urandom);
        e.emergency_flush = 1'($urandom);
        e.JumpSel         = 2'($urandom);
        if (e.MemtoReg == WSEL_LOAD) begin
            e.MemtoReg = WSEL_ALU;
        end
        name = "alu";
        if (kind < 4) begin
            e.port_o = (e.port_o & 32'hffff_fc00) | (slot << 2);
            if (kind >= 2 && stored[slot]) begin
                e.dREN     = 1'b1;
                e.MemtoReg = WSEL_LOAD;
                name       = "load";
            end else begin
                e.dWEN = 1'b1;
                name   = "store";
            end
        end
        if (n % 12 == 11) begin
            e.halt = 1'b1;
            e.dWEN = 1'b1;
            e.dREN = 1'b0;
            // no load happens, so write back the alu result
            if (e.MemtoReg == WSEL_LOAD) begin
                e.MemtoReg = WSEL_ALU;
            end
            e.port_o = (e.port_o & 32'hffff_fc00) | (slot << 2);
            name = "halt";
        end
        return e;
    endfunction

    // register write expected from the writeback rules
    function automatic regwrite_t expected_write(input execute_t e, input word_t load_val);
        regwrite_t r;
        r.wen  = e.RegWEN && (e.Rw != 5'd0);
        r.wsel = e.Rw;
        case (e.MemtoReg)
            WSEL_ALU:  r.wdat = e.port_o;
            WSEL_NPC:  r.wdat = e.NPC;
            WSEL_LOAD: r.wdat = load_val;
            default:   r.wdat = e.Imm_Ext;
        endcase
        return r;
    endfunction

    task automatic run_instr(input execute_t e, input string name, input int n);
        logic      do_flush;
        logic      go;
        int        slot;
        regwrite_t exp;
        logic      exp_halt;
        do_flush = ($urandom % 8) == 0;
        slot     = e.port_o[4:2];
        exp      = expected_write(e, mirror[slot]);
        exp_halt = e.halt;
        @(posedge CLK);
        execute_p <= e;
        ihit      <= 1'b0;
        freeze    <= 1'b0;
        flush     <= 1'b0;
        go = 1'b0;
        while (!go) begin
            @(posedge CLK);
            ihit   <= ($urandom % 4) != 0;
            freeze <= ($urandom % 8) == 0;
            flush  <= do_flush;
            @(negedge CLK);
            go = ihit && !freeze && !mem_busy;
        end
        // advancing edge, the execute latch moves on to a bubble
        @(posedge CLK);
        execute_p <= '0;
        ihit      <= 1'b0;
        freeze    <= 1'b0;
        flush     <= 1'b0;
        if (e.dWEN && !e.halt) begin
            mirror[slot] = e.port_b;
            stored[slot] = 1'b1;
        end
        if (do_flush) begin
            exp.wen  = 1'b0;
            exp_halt = 1'b0;
        end
        @(negedge CLK);
        if (regwrite.wen !== exp.wen) begin
            errors++;
            $display("** Error [%s #%0d] regwrite.wen expected %b actual %b",
                     name, n, exp.wen, regwrite.wen);
        end else if (exp.wen && (regwrite.wsel !== exp.wsel || regwrite.wdat !== exp.wdat)) begin
            errors++;
            $display("** Error [%s #%0d] regwrite expected %h actual %h",
                     name, n, exp, regwrite);
        end
        if (halt !== exp_halt) begin
            errors++;
            $display("** Error [%s #%0d] halt expected %b actual %b", name, n, exp_halt, halt);
        end
    endtask

    initial begin
        execute_t e;
        string    name;
        void'($urandom(32'ha5eb_23ac));
        nRST      = 1'b0;
        execute_p = '0;
        ihit      = 1'b0;
        flush     = 1'b0;
        freeze    = 1'b0;
        for (int i = 0; i < 8; i++) begin
            mirror[i] = '0;
            stored[i] = 1'b0;
        end
        repeat (2) @(posedge CLK);
        nRST <= 1'b1;
        for (int n = 0; n < NUM_INSTR; n++) begin
            e = make_instr(n, name);
            run_instr(e, name, n);
        end
        repeat (2) @(posedge CLK);
        $display("errors: %0d scoreboard, %0d assertion", errors, UUT.u_assert.fail_count);
        if (errors == 0 && UUT.u_assert.fail_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+source
source/cpu_types_pkg.sv
source/pipe_types_pkg.sv
source/memory_stage.sv
source/dmem_bus_master.sv
source/data_ram.sv
source/writeback_stage.sv
source/mem_wb_top.sv
test/mem_wb_assert.sv
test/mem_wb_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the memory/writeback testbench with Verilator.

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert \
    -f src.f \
    --top-module mem_wb_tb \
    -Mdir "$OBJ" \
    -o mem_wb_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$OBJ/mem_wb_sim" +verilator+error+limit+1000 > "$LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$LOG"
    echo "simulation exited with an error status"
    exit 1
fi

cat "$LOG"

if grep -q "^Test OK$" "$LOG"; then
    exit 0
else
    exit 1
fi
